/* include/vidc_consts.svh */
`ifndef VIDC_CONSTS_SVH
`define VIDC_CONSTS_SVH

// horizontal timing in pixel counts
`define VIDC_H_VISIBLE      16      // visible pixels per line
`define VIDC_H_TOTAL        24      // whole line incl. blanking
`define VIDC_HSYNC_START    18      // first hsync count
`define VIDC_HSYNC_END      21      // last hsync count

// vertical timing in lines
`define VIDC_V_VISIBLE      8       // visible lines, vblank starts here
`define VIDC_V_TOTAL        12      // whole frame
`define VIDC_VSYNC_START    9       // first vsync line
`define VIDC_VSYNC_END      10      // last vsync line

// memory sizes
`define VIDC_VRAM_AWIDTH    8       // 256 x 16-bit words
`define VIDC_PIX_PER_WORD   4       // 4-bit indexes per word
`define VIDC_PAL_ENTRIES    16      // 12-bit rgb entries

`endif

/* verilog/vidc_pkg.sv */
`default_nettype none

package vidc_pkg;

    // cpu visible register map
    typedef enum logic [3:0] {
        REG_WR_ADDR = 4'h0,     // vram write address
        REG_DATA    = 4'h1,     // write at wr addr, read prefetched word
        REG_RD_ADDR = 4'h2,     // write starts prefetch
        REG_PALETTE = 4'h3,     // [15:12] index, [11:0] rgb
        REG_INTR    = 4'h4,     // [8] mask, [0] clear / status
        REG_STATUS  = 4'h5      // [0] busy
    } reg_num_e;

    // vram handshake master states
    typedef enum logic [1:0] {
        BUS_IDLE      = 2'd0,
        BUS_DECODE    = 2'd1,   // command latched, req next
        BUS_WAIT_ACK  = 2'd2,
        BUS_WAIT_DROP = 2'd3    // req dropped, waiting on ack low
    } bus_state_e;

    typedef enum logic {
        VRAM_RD = 1'b0,
        VRAM_WR = 1'b1
    } vram_op_e;

endpackage

`default_nettype wire

/* verilog/reg_interface.sv */
`default_nettype none

`include "vidc_consts.svh"

module reg_interface(
    input  wire logic                           clk,
    input  wire logic                           reset_i,
    input  wire logic                           bus_cs_n_i,     // async select, low active
    input  wire logic                           bus_rd_nwr_i,   // 1 = read
    input  wire logic [3:0]                     bus_reg_num_i,
    input  wire logic                           bus_bytesel_i,  // 0 = high byte
    input  wire logic [7:0]                     bus_data_i,
    output logic      [7:0]                     bus_data_o,
    output logic                                regs_req_o,
    output vidc_pkg::vram_op_e                  regs_op_o,
    output logic      [`VIDC_VRAM_AWIDTH-1:0]   regs_addr_o,
    output logic      [15:0]                    regs_data_o,
    input  wire logic                           regs_ack_i,
    input  wire logic [15:0]                    vram_data_i,
    output logic                                pal_wr_o,
    output logic      [3:0]                     pal_index_o,
    output logic      [11:0]                    pal_rgb_o,
    output logic                                intr_mask_o,
    output logic                                intr_clear_o,
    input  wire logic                           intr_status_i
);

logic [2:0]                     cs_sync;        // [0],[1] sync, [2] edge detect
logic                           cs_fall;        // capture strobe, 3rd cycle of cs low
logic                           wr_stb;         // odd byte write completes a register
logic                           vram_start;     // accepted vram command
logic                           busy;
logic [7:0]                     wr_hi;          // even byte held for odd write
logic [`VIDC_VRAM_AWIDTH-1:0]   wr_addr;
logic [15:0]                    rd_data;        // prefetched vram word
logic [15:0]                    rd_word;        // register read mux
vidc_pkg::reg_num_e             bus_reg;
vidc_pkg::bus_state_e           bus_state;

assign bus_reg = vidc_pkg::reg_num_e'(bus_reg_num_i);
assign cs_fall = ~cs_sync[1] & cs_sync[2];
assign wr_stb  = cs_fall & ~bus_rd_nwr_i & bus_bytesel_i;
assign busy    = (bus_state != vidc_pkg::BUS_IDLE);   // until ack falls

// data/rd_addr writes while busy are dropped
assign vram_start = wr_stb & ~busy &
                    ((bus_reg == vidc_pkg::REG_DATA) || (bus_reg == vidc_pkg::REG_RD_ADDR));

always_comb begin
    case (bus_reg)
        vidc_pkg::REG_WR_ADDR: rd_word = 16'(wr_addr);
        vidc_pkg::REG_DATA:    rd_word = rd_data;
        vidc_pkg::REG_RD_ADDR: rd_word = 16'(regs_addr_o);      // last vram address
        vidc_pkg::REG_PALETTE: rd_word = {pal_index_o, pal_rgb_o};
        vidc_pkg::REG_INTR:    rd_word = {7'h00, intr_mask_o, 7'h00, intr_status_i};
        vidc_pkg::REG_STATUS:  rd_word = {15'h0000, busy};
        default:               rd_word = 16'h0000;
    endcase
end

// control state
always_ff @(posedge clk) begin
    if (reset_i) begin
        cs_sync      <= 3'b111;     // deselected
        bus_data_o   <= 8'h00;
        wr_addr      <= '0;
        bus_state    <= vidc_pkg::BUS_IDLE;
        regs_req_o   <= 1'b0;
        pal_wr_o     <= 1'b0;
        intr_mask_o  <= 1'b0;
        intr_clear_o <= 1'b0;
    end else begin
        cs_sync      <= {cs_sync[1:0], bus_cs_n_i};
        pal_wr_o     <= 1'b0;       // strobes
        intr_clear_o <= 1'b0;

        // reads answer on capture edge, held until next access
        if (cs_fall && bus_rd_nwr_i) begin
            bus_data_o <= bus_bytesel_i ? rd_word[7:0] : rd_word[15:8];
        end

        if (wr_stb) begin
            case (bus_reg)
                vidc_pkg::REG_WR_ADDR: wr_addr <= bus_data_i;
                vidc_pkg::REG_DATA: begin
                    if (!busy) begin
                        wr_addr <= wr_addr + 1'b1;     // auto increment
                    end
                end
                vidc_pkg::REG_PALETTE: pal_wr_o <= 1'b1;
                vidc_pkg::REG_INTR: begin
                    intr_mask_o  <= wr_hi[0];         // bit 8
                    intr_clear_o <= bus_data_i[0];
                end
                default: ;
            endcase
        end

        // four-phase handshake master
        case (bus_state)
            vidc_pkg::BUS_IDLE: begin
                if (vram_start) begin
                    bus_state <= vidc_pkg::BUS_DECODE;
                end
            end
            vidc_pkg::BUS_DECODE: begin
                regs_req_o <= 1'b1;     // op/addr/data already stable
                bus_state  <= vidc_pkg::BUS_WAIT_ACK;
            end
            vidc_pkg::BUS_WAIT_ACK: begin
                if (regs_ack_i) begin
                    regs_req_o <= 1'b0;
                    bus_state  <= vidc_pkg::BUS_WAIT_DROP;
                end
            end
            vidc_pkg::BUS_WAIT_DROP: begin
                if (!regs_ack_i) begin
                    bus_state <= vidc_pkg::BUS_IDLE;
                end
            end
            default: bus_state <= vidc_pkg::BUS_IDLE;
        endcase
    end
end

// payload registers
always_ff @(posedge clk) begin
    if (cs_fall && !bus_rd_nwr_i && !bus_bytesel_i) begin
        wr_hi <= bus_data_i;
    end
    if (vram_start) begin
        if (bus_reg == vidc_pkg::REG_DATA) begin
            regs_op_o   <= vidc_pkg::VRAM_WR;
            regs_addr_o <= wr_addr;
        end else begin
            regs_op_o   <= vidc_pkg::VRAM_RD;
            regs_addr_o <= bus_data_i;         // low byte is the address
        end
        regs_data_o <= {wr_hi, bus_data_i};
    end
    // read word valid while ack is high
    if (bus_state == vidc_pkg::BUS_WAIT_ACK && regs_ack_i && regs_op_o == vidc_pkg::VRAM_RD) begin
        rd_data <= vram_data_i;
    end
    if (wr_stb && bus_reg == vidc_pkg::REG_PALETTE) begin
        pal_index_o <= wr_hi[7:4];
        pal_rgb_o   <= {wr_hi[3:0], bus_data_i};
    end
end

// req only drops after the arbiter has acked
a_req_held: assert property (@(posedge clk) disable iff (reset_i)
    $fell(regs_req_o) |-> $past(regs_ack_i));

endmodule

`default_nettype wire

/* verilog/vram_arb.sv */
`default_nettype none

`include "vidc_consts.svh"

module vram_arb(
    input  wire logic                           clk,
    input  wire logic                           reset_i,
    input  wire logic                           vgen_sel_i,     // video slot, top priority
    input  wire logic [`VIDC_VRAM_AWIDTH-1:0]   vgen_addr_i,
    input  wire logic                           regs_req_i,
    input  wire vidc_pkg::vram_op_e             regs_op_i,
    input  wire logic [`VIDC_VRAM_AWIDTH-1:0]   regs_addr_i,
    input  wire logic [15:0]                    regs_data_i,
    output logic                                regs_ack_o,
    output logic      [15:0]                    vram_data_o     // shared read data
);

logic [15:0]    vram_mem [2**`VIDC_VRAM_AWIDTH];
logic           cpu_go;     // cpu owns the port this cycle

// pending, not yet acked, and no video slot
assign cpu_go = regs_req_i & ~regs_ack_o & ~vgen_sel_i;

// single registered port
always_ff @(posedge clk) begin
    if (vgen_sel_i) begin
        vram_data_o <= vram_mem[vgen_addr_i];   // word ready next cycle
    end else if (cpu_go) begin
        if (regs_op_i == vidc_pkg::VRAM_WR) begin
            vram_mem[regs_addr_i] <= regs_data_i;
        end
        vram_data_o <= vram_mem[regs_addr_i];   // valid with ack
    end
end

// ack side of four-phase handshake
always_ff @(posedge clk) begin
    if (reset_i) begin
        regs_ack_o <= 1'b0;
    end else if (regs_ack_o) begin
        regs_ack_o <= regs_req_i;   // hold until req falls
    end else begin
        regs_ack_o <= cpu_go;
    end
end

// master holds req and its payload until acked
a_req_stable: assert property (@(posedge clk) disable iff (reset_i)
    regs_req_i && !regs_ack_o |=> regs_req_i && $stable(regs_op_i) &&
                                  $stable(regs_addr_i) && $stable(regs_data_i));

// video takes 1 slot in 4, so a cpu request is served within 3 cycles
a_ack_latency: assert property (@(posedge clk) disable iff (reset_i)
    $rose(regs_req_i) |-> ##[1:3] regs_ack_o);

endmodule

`default_nettype wire

/* verilog/video_gen.sv */
`default_nettype none

`include "vidc_consts.svh"

module video_gen(
    input  wire logic                           clk,
    input  wire logic                           reset_i,
    output logic                                vram_sel_o,     // one cycle fetch slot
    output logic      [`VIDC_VRAM_AWIDTH-1:0]   vram_addr_o,
    input  wire logic [15:0]                    vram_data_i,    // valid cycle after sel
    output logic      [3:0]                     pix_index_o,
    output logic                                de_o,
    output logic                                hsync_o,
    output logic                                vsync_o,
    output logic                                intr_signal_o   // vblank start pulse
);

localparam int H_BITS         = $clog2(`VIDC_H_TOTAL);
localparam int V_BITS         = $clog2(`VIDC_V_TOTAL);
localparam int WORDS_PER_LINE = `VIDC_H_VISIBLE / `VIDC_PIX_PER_WORD;

logic [H_BITS-1:0]  h_count;    // leads the outputs by one cycle
logic [V_BITS-1:0]  v_count;
logic               h_last;
logic               v_last;
logic               grp_start;  // first pixel of a 4-pixel group
logic [11:0]        pix_shift;  // remaining nibbles of current word
int                 fetch_word;

assign h_last    = (h_count == `VIDC_H_TOTAL - 1);
assign v_last    = (v_count == `VIDC_V_TOTAL - 1);
assign grp_start = (h_count % `VIDC_PIX_PER_WORD == 0);

// fetch one count ahead of each group
always_comb begin
    if (h_last) begin
        // first group of next visible line, wraps to line 0
        vram_sel_o = v_last || (v_count < `VIDC_V_VISIBLE - 1);
        fetch_word = v_last ? 0 : (int'(v_count) + 1) * WORDS_PER_LINE;
    end else begin
        vram_sel_o = (v_count < `VIDC_V_VISIBLE) &&
                     (h_count < `VIDC_H_VISIBLE - 1) &&
                     (h_count % `VIDC_PIX_PER_WORD == `VIDC_PIX_PER_WORD - 1);
        fetch_word = int'(v_count) * WORDS_PER_LINE +
                     int'(h_count) / `VIDC_PIX_PER_WORD + 1;
    end
    vram_addr_o = `VIDC_VRAM_AWIDTH'(fetch_word);
end

// raster counters and registered timing outputs
always_ff @(posedge clk) begin
    if (reset_i) begin
        h_count       <= '0;
        v_count       <= '0;
        de_o          <= 1'b0;
        hsync_o       <= 1'b0;
        vsync_o       <= 1'b0;
        intr_signal_o <= 1'b0;
    end else begin
        if (h_last) begin
            h_count <= '0;
            v_count <= v_last ? '0 : v_count + 1'b1;
        end else begin
            h_count <= h_count + 1'b1;
        end
        de_o    <= (h_count < `VIDC_H_VISIBLE) && (v_count < `VIDC_V_VISIBLE);
        hsync_o <= (h_count >= `VIDC_HSYNC_START) && (h_count <= `VIDC_HSYNC_END);
        vsync_o <= (v_count >= `VIDC_VSYNC_START) && (v_count <= `VIDC_VSYNC_END);
        intr_signal_o <= (h_count == 0) && (v_count == `VIDC_V_VISIBLE);   // vblank
    end
end

// nibble 0 straight from vram, rest from shifter
always_ff @(posedge clk) begin
    if (grp_start) begin
        pix_index_o <= vram_data_i[3:0];
        pix_shift   <= vram_data_i[15:4];
    end else begin
        pix_index_o <= pix_shift[3:0];
        pix_shift   <= {4'h0, pix_shift[11:4]};
    end
end

a_h_range: assert property (@(posedge clk) disable iff (reset_i)
    h_count < `VIDC_H_TOTAL);

endmodule

`default_nettype wire

/* verilog/color_lut.sv */
`default_nettype none

`include "vidc_consts.svh"

module color_lut(
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           pal_wr_i,       // cpu palette write strobe
    input  wire logic [3:0]     pal_index_i,
    input  wire logic [11:0]    pal_rgb_i,
    input  wire logic [3:0]     pix_index_i,
    input  wire logic           de_i,
    input  wire logic           hsync_i,
    input  wire logic           vsync_i,
    output logic      [3:0]     red_o,
    output logic      [3:0]     green_o,
    output logic      [3:0]     blue_o,
    output logic                dv_de_o,
    output logic                hsync_o,
    output logic                vsync_o
);

logic [11:0]    pal_mem [`VIDC_PAL_ENTRIES];
logic [11:0]    rgb_q;          // registered lookup
logic           de_1;           // timing delayed to match lookup
logic           hsync_1;
logic           vsync_1;

always_ff @(posedge clk) begin
    if (pal_wr_i) begin
        pal_mem[pal_index_i] <= pal_rgb_i;
    end
    rgb_q <= pal_mem[pix_index_i];
end

// two stage output pipe
always_ff @(posedge clk) begin
    if (reset_i) begin
        de_1    <= 1'b0;
        hsync_1 <= 1'b0;
        vsync_1 <= 1'b0;
        dv_de_o <= 1'b0;
        hsync_o <= 1'b0;
        vsync_o <= 1'b0;
        red_o   <= 4'h0;
        green_o <= 4'h0;
        blue_o  <= 4'h0;
    end else begin
        de_1    <= de_i;
        hsync_1 <= hsync_i;
        vsync_1 <= vsync_i;
        dv_de_o <= de_1;
        hsync_o <= hsync_1;
        vsync_o <= vsync_1;
        // black outside display area
        red_o   <= de_1 ? rgb_q[11:8] : 4'h0;
        green_o <= de_1 ? rgb_q[7:4]  : 4'h0;
        blue_o  <= de_1 ? rgb_q[3:0]  : 4'h0;
    end
end

endmodule

`default_nettype wire

/* verilog/video_main.sv */
`default_nettype none

`include "vidc_consts.svh"

module video_main(
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           bus_cs_n_i,
    input  wire logic           bus_rd_nwr_i,
    input  wire logic [3:0]     bus_reg_num_i,
    input  wire logic           bus_bytesel_i,
    input  wire logic [7:0]     bus_data_i,
    output logic      [7:0]     bus_data_o,
    output logic                bus_intr_o,     // cpu interrupt, one cycle
    output logic      [3:0]     red_o,
    output logic      [3:0]     green_o,
    output logic      [3:0]     blue_o,
    output logic                hsync_o,
    output logic                vsync_o,
    output logic                dv_de_o
);

// cpu side vram handshake
logic                           regs_req;
vidc_pkg::vram_op_e             regs_op;
logic [`VIDC_VRAM_AWIDTH-1:0]   regs_addr;
logic [15:0]                    regs_data;
logic                           regs_ack;
logic [15:0]                    vram_data;      // shared by cpu and video

// video fetch and pixel stream
logic                           vgen_sel;
logic [`VIDC_VRAM_AWIDTH-1:0]   vgen_addr;
logic [3:0]                     pix_index;
logic                           vgen_de;
logic                           vgen_hsync;
logic                           vgen_vsync;

logic                           pal_wr;
logic [3:0]                     pal_index;
logic [11:0]                    pal_rgb;

logic                           intr_mask;
logic                           intr_clear;     // cpu clear strobe
logic                           intr_signal;    // vblank pulse
logic                           intr_status;

reg_interface u_reg_interface(
    .clk(clk),                  .reset_i(reset_i),
    .bus_cs_n_i(bus_cs_n_i),    .bus_rd_nwr_i(bus_rd_nwr_i),
    .bus_reg_num_i(bus_reg_num_i), .bus_bytesel_i(bus_bytesel_i),
    .bus_data_i(bus_data_i),    .bus_data_o(bus_data_o),
    .regs_req_o(regs_req),      .regs_op_o(regs_op),
    .regs_addr_o(regs_addr),    .regs_data_o(regs_data),
    .regs_ack_i(regs_ack),      .vram_data_i(vram_data),
    .pal_wr_o(pal_wr),          .pal_index_o(pal_index),    .pal_rgb_o(pal_rgb),
    .intr_mask_o(intr_mask),    .intr_clear_o(intr_clear),
    .intr_status_i(intr_status)
);

vram_arb u_vram_arb(
    .clk(clk),                  .reset_i(reset_i),
    .vgen_sel_i(vgen_sel),      .vgen_addr_i(vgen_addr),
    .regs_req_i(regs_req),      .regs_op_i(regs_op),
    .regs_addr_i(regs_addr),    .regs_data_i(regs_data),
    .regs_ack_o(regs_ack),      .vram_data_o(vram_data)
);

video_gen u_video_gen(
    .clk(clk),                  .reset_i(reset_i),
    .vram_sel_o(vgen_sel),      .vram_addr_o(vgen_addr),    .vram_data_i(vram_data),
    .pix_index_o(pix_index),    .de_o(vgen_de),
    .hsync_o(vgen_hsync),       .vsync_o(vgen_vsync),
    .intr_signal_o(intr_signal)
);

color_lut u_color_lut(
    .clk(clk),                  .reset_i(reset_i),
    .pal_wr_i(pal_wr),          .pal_index_i(pal_index),    .pal_rgb_i(pal_rgb),
    .pix_index_i(pix_index),    .de_i(vgen_de),
    .hsync_i(vgen_hsync),       .vsync_i(vgen_vsync),
    .red_o(red_o),              .green_o(green_o),          .blue_o(blue_o),
    .dv_de_o(dv_de_o),          .hsync_o(hsync_o),          .vsync_o(vsync_o)
);

// vblank interrupt status and cpu strobe
always_ff @(posedge clk) begin
    if (reset_i) begin
        bus_intr_o  <= 1'b0;
        intr_status <= 1'b0;
    end else begin
        bus_intr_o <= intr_signal & intr_mask & ~intr_status;  // only on new status
        if (intr_clear) begin
            intr_status <= 1'b0;        // clear beats a same-cycle signal
        end else if (intr_signal) begin
            intr_status <= 1'b1;
        end
    end
end

endmodule

`default_nettype wire

/* verif/tb_video_main.sv */
`default_nettype none

`include "vidc_consts.svh"

module tb_video_main;

localparam int FRAME_CYCLES  = `VIDC_H_TOTAL * `VIDC_V_TOTAL;          // 288
localparam int FRAME_PIXELS  = `VIDC_H_VISIBLE * `VIDC_V_VISIBLE;      // 128
localparam int HSYNC_CYCLES  = `VIDC_HSYNC_END - `VIDC_HSYNC_START + 1;
localparam int VSYNC_CYCLES  = (`VIDC_VSYNC_END - `VIDC_VSYNC_START + 1) * `VIDC_H_TOTAL;
// 8 frames plus 200 bus ops of 16 cycles, rounded up to the next thousand
localparam int TIMEOUT_CYCLES = ((8 * FRAME_CYCLES + 200 * 16) / 1000 + 1) * 1000;

logic           clk = 1'b0;
logic           reset_i;
logic           bus_cs_n_i;
logic           bus_rd_nwr_i;
logic [3:0]     bus_reg_num_i;
logic           bus_bytesel_i;
logic [7:0]     bus_data_i;
logic [7:0]     bus_data_o;
logic           bus_intr_o;
logic [3:0]     red_o;
logic [3:0]     green_o;
logic [3:0]     blue_o;
logic           hsync_o;
logic           vsync_o;
logic           dv_de_o;

// reference model
logic [15:0]    vram_m [2**`VIDC_VRAM_AWIDTH];
logic [11:0]    pal_m [`VIDC_PAL_ENTRIES];
logic [7:0]     wr_addr_m;
logic           mask_m;
logic           status_m;

integer seed = 19;
integer cycle_count = 0;
integer error_count = 0;
integer test_errors = 0;    // error count at start of current test
integer tests_run = 0;
integer tests_ok = 0;
integer checks_done = 0;

video_main u_video_main(
    .clk(clk),                      .reset_i(reset_i),
    .bus_cs_n_i(bus_cs_n_i),        .bus_rd_nwr_i(bus_rd_nwr_i),
    .bus_reg_num_i(bus_reg_num_i),  .bus_bytesel_i(bus_bytesel_i),
    .bus_data_i(bus_data_i),        .bus_data_o(bus_data_o),
    .bus_intr_o(bus_intr_o),
    .red_o(red_o),                  .green_o(green_o),      .blue_o(blue_o),
    .hsync_o(hsync_o),              .vsync_o(vsync_o),      .dv_de_o(dv_de_o)
);

always #5 clk = ~clk;

// watchdog
always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
        $display("timeout: run went past %0d cycles without finishing", TIMEOUT_CYCLES);
        $display("Test failed");
        $finish;
    end
end

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    checks_done = checks_done + 1;
    if (expected !== actual) begin
        error_count = error_count + 1;
        $display("MISMATCH %s: expected %0h, actual %0h", name, expected, actual);
    end
endtask

task automatic end_test(input string name);
    integer errs;
    errs = error_count - test_errors;
    tests_run = tests_run + 1;
    if (errs == 0) begin
        tests_ok = tests_ok + 1;
    end
    $display("%-16s %s (%0d errors)", name, (errs == 0) ? "ok" : "FAIL", errs);
    test_errors = error_count;
endtask

// one access, called and returning on a falling edge
task automatic drive_cs(input logic rd, input vidc_pkg::reg_num_e num, input logic bsel,
                        input logic [7:0] wdata, output logic [7:0] rdata);
    bus_rd_nwr_i  = rd;
    bus_reg_num_i = num;
    bus_bytesel_i = bsel;
    bus_data_i    = wdata;
    bus_cs_n_i    = 1'b0;
    repeat (4) @(negedge clk);
    rdata = bus_data_o;         // end of low phase, long after capture
    bus_cs_n_i = 1'b1;
    repeat (4) @(negedge clk);
endtask

task automatic bus_write(input vidc_pkg::reg_num_e num, input logic bsel, input logic [7:0] d);
    logic [7:0] unused;
    drive_cs(1'b0, num, bsel, d, unused);
endtask

task automatic bus_read(input vidc_pkg::reg_num_e num, input logic bsel,
                        output logic [7:0] d);
    drive_cs(1'b1, num, bsel, 8'h00, d);
endtask

task automatic wait_not_busy();
    logic [7:0]             st;
    integer                 polls;
    vidc_pkg::bus_state_e   fsm;
    polls = 0;
    st = 8'h01;
    while (st[0] && polls < 8) begin
        bus_read(vidc_pkg::REG_STATUS, 1'b1, st);
        polls = polls + 1;
    end
    if (st[0]) begin
        fsm = u_video_main.u_reg_interface.bus_state;
        error_count = error_count + 1;
        $display("busy flag never cleared after a VRAM access, handshake FSM in %s",
                 fsm.name());
    end
endtask

// high byte first, odd byte completes the register
task automatic write_reg(input vidc_pkg::reg_num_e num, input logic [15:0] d);
    bus_write(num, 1'b0, d[15:8]);
    bus_write(num, 1'b1, d[7:0]);
    wait_not_busy();
endtask

task automatic read_reg(input vidc_pkg::reg_num_e num, output logic [15:0] d);
    bus_read(num, 1'b0, d[15:8]);
    bus_read(num, 1'b1, d[7:0]);
endtask

function automatic logic [11:0] expected_rgb(input integer k);
    logic [15:0]    word;
    logic [3:0]     nib;
    word = vram_m[k / `VIDC_PIX_PER_WORD];
    nib  = word[4 * (k % `VIDC_PIX_PER_WORD) +: 4];    // nibble 0 is bits 3:0
    return pal_m[nib];
endfunction

task automatic wait_vsync_fall();
    while (!vsync_o) @(negedge clk);
    while (vsync_o) @(negedge clk);
endtask

// runs from one vsync fall to the next, sampled on falling edges
task automatic watch_frame(input bit check_pixels, input bit check_timing);
    integer         cycles;
    integer         pix;
    integer         de_run;
    integer         hs_run;
    integer         lines;
    integer         hs_pulses;
    integer         vs_cycles;
    logic           prev_de;
    logic           prev_hs;
    logic           prev_vs;
    logic [11:0]    rgb;
    cycles = 0;
    pix = 0;
    de_run = 0;
    hs_run = 0;
    lines = 0;
    hs_pulses = 0;
    vs_cycles = 0;
    prev_de = 1'b0;
    prev_hs = 1'b0;
    prev_vs = 1'b0;
    while (!(prev_vs && !vsync_o) && cycles < 2 * FRAME_CYCLES) begin
        rgb = {red_o, green_o, blue_o};
        if (dv_de_o) begin
            if (check_pixels && pix < FRAME_PIXELS) begin
                check_value("frame_pixel", expected_rgb(pix), rgb);
            end
            pix = pix + 1;
            de_run = de_run + 1;
        end else begin
            if (check_pixels) begin
                check_value("blank_rgb", 0, rgb);     // black outside de
            end
            if (prev_de) begin
                if (check_timing) check_value("de_run", `VIDC_H_VISIBLE, de_run);
                lines = lines + 1;
                de_run = 0;
            end
        end
        if (hsync_o) begin
            hs_run = hs_run + 1;
        end else if (prev_hs) begin
            if (check_timing) check_value("hsync_width", HSYNC_CYCLES, hs_run);
            hs_pulses = hs_pulses + 1;
            hs_run = 0;
        end
        if (vsync_o) vs_cycles = vs_cycles + 1;
        prev_de = dv_de_o;
        prev_hs = hsync_o;
        prev_vs = vsync_o;
        cycles = cycles + 1;
        @(negedge clk);
    end
    if (check_pixels) check_value("frame_pixels", FRAME_PIXELS, pix);
    if (check_timing) begin
        check_value("visible_lines", `VIDC_V_VISIBLE, lines);
        check_value("hsync_pulses", `VIDC_V_TOTAL, hs_pulses);
        check_value("vsync_width", VSYNC_CYCLES, vs_cycles);
        check_value("frame_length", FRAME_CYCLES, cycles);
    end
endtask

// one frame of bus_intr_o, always contains one vblank
task automatic count_intr_pulses(output integer n);
    n = 0;
    repeat (FRAME_CYCLES) begin
        if (bus_intr_o) n = n + 1;
        @(negedge clk);
    end
endtask

initial begin
    logic [15:0]    d;
    logic [15:0]    w;
    logic [7:0]     base;
    logic [11:0]    rgb;
    integer         n;
    reset_i       = 1'b1;
    bus_cs_n_i    = 1'b1;
    bus_rd_nwr_i  = 1'b1;
    bus_reg_num_i = 4'h0;
    bus_bytesel_i = 1'b0;
    bus_data_i    = 8'h00;
    mask_m        = 1'b0;
    status_m      = 1'b0;

    // reset state, outputs looked at in the last reset cycle
    repeat (4) @(negedge clk);
    check_value("reset_intr", 0, bus_intr_o);
    check_value("reset_de", 0, dv_de_o);
    check_value("reset_hsync", 0, hsync_o);
    check_value("reset_vsync", 0, vsync_o);
    check_value("reset_rgb", 0, {red_o, green_o, blue_o});
    reset_i = 1'b0;
    read_reg(vidc_pkg::REG_INTR, d);
    check_value("reset_reg_intr", 0, d);
    end_test("reset_state");

    // vram round trip from a random base
    base = $random(seed);
    write_reg(vidc_pkg::REG_WR_ADDR, {8'h00, base});
    wr_addr_m = base;
    repeat (8) begin
        w = $random(seed);
        write_reg(vidc_pkg::REG_DATA, w);
        vram_m[wr_addr_m] = w;
        wr_addr_m = wr_addr_m + 1'b1;       // wraps like the 8-bit address
    end
    read_reg(vidc_pkg::REG_WR_ADDR, d);
    check_value("wr_addr_incr", {8'h00, wr_addr_m}, d);
    for (int i = 0; i < 8; i++) begin
        write_reg(vidc_pkg::REG_RD_ADDR, {8'h00, 8'(base + i)});
        read_reg(vidc_pkg::REG_DATA, d);
        check_value("vram_round_trip", vram_m[8'(base + i)], d);
    end
    end_test("vram_round_trip");

    // frame contents, words 0..31 and the whole palette
    write_reg(vidc_pkg::REG_WR_ADDR, 16'h0000);
    for (int i = 0; i < FRAME_PIXELS / `VIDC_PIX_PER_WORD; i++) begin
        w = $random(seed);
        write_reg(vidc_pkg::REG_DATA, w);
        vram_m[i] = w;
    end
    for (int i = 0; i < `VIDC_PAL_ENTRIES; i++) begin
        rgb = $random(seed);
        write_reg(vidc_pkg::REG_PALETTE, {4'(i), rgb});
        pal_m[i] = rgb;
    end
    wait_vsync_fall();
    watch_frame(1'b1, 1'b0);
    end_test("displayed_frame");

    watch_frame(1'b0, 1'b1);                // starts at the next vsync fall
    end_test("raster_timing");

    // interrupt, mask on, clear on the same write
    wait_vsync_fall();                      // next vblank is 9 lines away
    write_reg(vidc_pkg::REG_INTR, 16'h0101);
    mask_m = 1'b1;
    status_m = 1'b0;
    count_intr_pulses(n);
    check_value("intr_pulse", (mask_m && !status_m) ? 1 : 0, n);
    status_m = 1'b1;
    read_reg(vidc_pkg::REG_INTR, d);
    check_value("intr_status_set", {7'h00, mask_m, 7'h00, status_m}, d);
    count_intr_pulses(n);
    check_value("intr_no_repeat", (mask_m && !status_m) ? 1 : 0, n);
    wait_vsync_fall();
    write_reg(vidc_pkg::REG_INTR, 16'h0101);
    status_m = 1'b0;
    read_reg(vidc_pkg::REG_INTR, d);
    check_value("intr_cleared", {7'h00, mask_m, 7'h00, status_m}, d);
    write_reg(vidc_pkg::REG_INTR, 16'h0000); // mask off
    mask_m = 1'b0;
    count_intr_pulses(n);
    check_value("intr_masked_off", (mask_m && !status_m) ? 1 : 0, n);
    status_m = 1'b1;                        // status still follows vblank
    read_reg(vidc_pkg::REG_INTR, d);
    check_value("intr_status_unmasked", {7'h00, mask_m, 7'h00, status_m}, d);
    end_test("interrupt");

    $display("summary: %0d tests, %0d ok, %0d checks, %0d errors",
             tests_run, tests_ok, checks_done, error_count);
    if (error_count == 0) begin
        $display("Test completed successfully");
    end else begin
        $display("Test failed");
    end
    $finish;
end

endmodule

`default_nettype wire

/* sim.f */
+incdir+include
verilog/vidc_pkg.sv
verilog/reg_interface.sv
verilog/vram_arb.sv
verilog/video_gen.sv
verilog/color_lut.sv
verilog/video_main.sv
verif/tb_video_main.sv
